/* Bender.yml */
package:
  name: little_computer

sources:
  - src/lc_pkg.sv
  - src/uart_rx.sv
  - src/program_loader.sv
  - src/cpu.sv
  - src/mem_map.sv
  - src/little_computer.sv
  - target: test
    files:
      - tests/little_computer_tb.sv

/* src.f */
src/lc_pkg.sv
src/uart_rx.sv
src/program_loader.sv
src/cpu.sv
src/mem_map.sv
src/little_computer.sv
tests/little_computer_tb.sv

/* src/cpu.sv */
`default_nettype none

module cpu import lc_pkg::*; (
    input  logic     sysclk,
    input  logic     sysrst,
    input  logic     run,
    output mem_req_t req,
    input  word_t    rdata,
    input  logic     mem_stall,
    output logic     halted
);

    cpu_state_e state;
    addr_t      pc;
    word_t      acc;
    instr_t     ir;
    opcode_e    opcode;
    addr_t      operand_addr;

    // Opcode sits in the same bits in both formats
    assign opcode       = ir.mem_fmt.opcode;
    assign operand_addr = ir.mem_fmt.addr;
    assign halted       = (state == cpu_halt);

    always_ff @(posedge sysclk) begin
        if (!sysrst || !run) begin
            state <= cpu_fetch;
            pc    <= '0;
            acc   <= '0;
        end else begin
            case (state)
                cpu_fetch: begin
                    state <= cpu_fetch_wait;
                end
                cpu_fetch_wait: begin
                    pc    <= pc + addr_t'(1);
                    state <= cpu_exec;
                end
                cpu_exec: begin
                    case (opcode)
                        op_ldi: begin
                            acc   <= word_t'(ir.imm_fmt.imm);
                            state <= cpu_fetch;
                        end
                        op_ld, op_add, op_sub: begin
                            state <= cpu_mem_wait;
                        end
                        op_st: begin
                            // Wait here while the output port is full
                            if (!mem_stall) begin
                                state <= cpu_fetch;
                            end
                        end
                        op_jmp: begin
                            pc    <= operand_addr;
                            state <= cpu_fetch;
                        end
                        op_jz: begin
                            if (acc == '0) begin
                                pc <= operand_addr;
                            end
                            state <= cpu_fetch;
                        end
                        op_halt: begin
                            state <= cpu_halt;
                        end
                        default: state <= cpu_fetch;
                    endcase
                end
                cpu_mem_wait: begin
                    case (opcode)
                        op_add:  acc <= acc + rdata;
                        op_sub:  acc <= acc - rdata;
                        default: acc <= rdata;
                    endcase
                    state <= cpu_fetch;
                end
                cpu_halt: begin
                    state <= cpu_halt;
                end
                default: state <= cpu_fetch;
            endcase
        end
    end

    always_ff @(posedge sysclk) begin
        if (state == cpu_fetch_wait) begin
            ir <= rdata;
        end
    end

    always_comb begin
        req = '0;
        case (state)
            cpu_fetch: begin
                req.valid = 1'b1;
                req.addr  = pc;
            end
            cpu_exec: begin
                req.addr  = operand_addr;
                req.wdata = acc;
                case (opcode)
                    op_ld, op_add, op_sub: req.valid = 1'b1;
                    op_st: begin
                        req.valid = ~mem_stall;
                        req.we    = 1'b1;
                    end
                    default: req.valid = 1'b0;
                endcase
            end
            default: req = '0;
        endcase
    end

endmodule

`default_nettype wire

/* src/lc_pkg.sv */
`default_nettype none

package lc_pkg;

    localparam int word_width = 16;
    localparam int addr_width = 8;

    typedef logic [word_width-1:0] word_t;
    typedef logic [addr_width-1:0] addr_t;

    localparam addr_t out_port_addr = 8'hFF;

    // UART bit timing in sysclk cycles
    localparam int clks_per_bit = 8;
    localparam int baud_cnt_width = $clog2(clks_per_bit) + 1;

    typedef logic [baud_cnt_width-1:0] baud_cnt_t;

    localparam baud_cnt_t baud_last = baud_cnt_t'(clks_per_bit - 1);
    localparam baud_cnt_t baud_half = baud_cnt_t'(clks_per_bit / 2 - 1);

    typedef enum logic [3:0] {
        op_ldi  = 4'd0,
        op_ld   = 4'd1,
        op_st   = 4'd2,
        op_add  = 4'd3,
        op_sub  = 4'd4,
        op_jmp  = 4'd5,
        op_jz   = 4'd6,
        op_halt = 4'd15
    } opcode_e;

    // Same instruction word, immediate or memory operand view
    typedef union packed {
        struct packed {
            opcode_e     opcode;
            logic [11:0] imm;
        } imm_fmt;
        struct packed {
            opcode_e    opcode;
            logic [3:0] rsvd;
            addr_t      addr;
        } mem_fmt;
    } instr_t;

    typedef struct packed {
        logic  valid;
        logic  we;
        addr_t addr;
        word_t wdata;
    } mem_req_t;

    typedef struct packed {
        logic  valid;
        word_t data;
    } out_beat_t;

    typedef enum logic [1:0] {
        rx_idle,
        rx_start,
        rx_data,
        rx_stop
    } rx_state_e;

    typedef enum logic [2:0] {
        cpu_fetch,
        cpu_fetch_wait,
        cpu_exec,
        cpu_mem_wait,
        cpu_halt
    } cpu_state_e;

endpackage

`default_nettype wire

/* src/little_computer.sv */
`default_nettype none

module little_computer import lc_pkg::*; (
    input  logic      sysclk,
    input  logic      sysrst,
    input  logic      rx,
    input  logic      load_en,
    input  logic      out_ready,
    output out_beat_t out_beat,
    output logic      halted
);

    logic [7:0] rx_byte;
    logic       rx_byte_valid;
    mem_req_t   load_req;
    mem_req_t   cpu_req;
    logic       cpu_run;
    word_t      rdata;
    logic       mem_stall;

    uart_rx uart_rx_i (
        .sysclk     (sysclk),
        .sysrst     (sysrst),
        .rx         (rx),
        .data       (rx_byte),
        .data_valid (rx_byte_valid)
    );

    program_loader program_loader_i (
        .sysclk     (sysclk),
        .sysrst     (sysrst),
        .byte_data  (rx_byte),
        .byte_valid (rx_byte_valid),
        .load_en    (load_en),
        .load_req   (load_req),
        .cpu_run    (cpu_run)
    );

    cpu cpu_i (
        .sysclk    (sysclk),
        .sysrst    (sysrst),
        .run       (cpu_run),
        .req       (cpu_req),
        .rdata     (rdata),
        .mem_stall (mem_stall),
        .halted    (halted)
    );

    mem_map mem_map_i (
        .sysclk    (sysclk),
        .sysrst    (sysrst),
        .cpu_run   (cpu_run),
        .load_req  (load_req),
        .cpu_req   (cpu_req),
        .rdata     (rdata),
        .mem_stall (mem_stall),
        .out_beat  (out_beat),
        .out_ready (out_ready)
    );

endmodule

`default_nettype wire

/* src/mem_map.sv */
`default_nettype none

module mem_map import lc_pkg::*; (
    input  logic      sysclk,
    input  logic      sysrst,
    input  logic      cpu_run,
    input  mem_req_t  load_req,
    input  mem_req_t  cpu_req,
    output word_t     rdata,
    output logic      mem_stall,
    output out_beat_t out_beat,
    input  logic      out_ready
);

    mem_req_t sel;
    logic     port_hit;
    logic     ram_write;
    logic     ram_read;
    logic     out_valid;
    word_t    out_data;
    word_t    ram [0:(1 << addr_width) - 1];

    // Loader owns memory while the CPU is held
    assign sel = cpu_run ? cpu_req : load_req;

    // Only CPU stores reach the port, the loader can fill every word
    assign port_hit  = cpu_run & sel.valid & sel.we & (sel.addr == out_port_addr);
    assign ram_write = sel.valid & sel.we & ~port_hit;
    assign ram_read  = sel.valid & ~sel.we;

    always_ff @(posedge sysclk) begin
        if (ram_write) begin
            ram[sel.addr] <= sel.wdata;
        end
        if (ram_read) begin
            rdata <= ram[sel.addr];
        end
    end

    // Output register holds until accepted
    always_ff @(posedge sysclk) begin
        if (!sysrst) begin
            out_valid <= 1'b0;
        end else if (port_hit) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge sysclk) begin
        if (port_hit) begin
            out_data <= sel.wdata;
        end
    end

    assign mem_stall = out_valid & ~out_ready;
    assign out_beat  = '{valid: out_valid, data: out_data};

endmodule

`default_nettype wire

/* src/program_loader.sv */
`default_nettype none

module program_loader import lc_pkg::*; (
    input  logic       sysclk,
    input  logic       sysrst,
    input  logic [7:0] byte_data,
    input  logic       byte_valid,
    input  logic       load_en,
    output mem_req_t   load_req,
    output logic       cpu_run
);

    logic       load_en_q;
    logic       load_rise;
    logic       load_fall;
    logic       take_byte;
    logic       phase;
    logic       req_valid;
    logic [7:0] hi_byte;
    addr_t      count;
    addr_t      req_addr;
    word_t      req_data;

    assign load_rise = load_en & ~load_en_q;
    assign load_fall = ~load_en & load_en_q;
    assign take_byte = load_en & byte_valid;

    // Hold the CPU while loading, release one cycle after load_en drops
    always_ff @(posedge sysclk) begin
        if (!sysrst) begin
            load_en_q <= 1'b0;
            phase     <= 1'b0;
            count     <= '0;
            req_valid <= 1'b0;
            cpu_run   <= 1'b0;
        end else begin
            load_en_q <= load_en;
            req_valid <= 1'b0;
            if (load_rise) begin
                count   <= '0;
                phase   <= 1'b0;
                cpu_run <= 1'b0;
            end else if (take_byte) begin
                phase <= ~phase;
                if (phase) begin
                    req_valid <= 1'b1;
                    count     <= count + addr_t'(1);
                end
            end
            if (load_fall) begin
                cpu_run <= 1'b1;
            end
        end
    end

    // High byte arrives first
    always_ff @(posedge sysclk) begin
        if (take_byte) begin
            if (!phase) begin
                hi_byte <= byte_data;
            end else begin
                req_addr <= count;
                req_data <= {hi_byte, byte_data};
            end
        end
    end

    assign load_req = '{valid: req_valid, we: 1'b1, addr: req_addr, wdata: req_data};

endmodule

`default_nettype wire

/* src/uart_rx.sv */
`default_nettype none

module uart_rx import lc_pkg::*; (
    input  logic       sysclk,
    input  logic       sysrst,
    input  logic       rx,
    output logic [7:0] data,
    output logic       data_valid
);

    logic      rx_meta;
    logic      rx_sync;
    rx_state_e state;
    baud_cnt_t bit_cnt;
    logic [2:0] bit_idx;

    // Two-flop synchronizer, line idles high
    always_ff @(posedge sysclk) begin
        if (!sysrst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge sysclk) begin
        if (!sysrst) begin
            state      <= rx_idle;
            bit_cnt    <= '0;
            bit_idx    <= '0;
            data_valid <= 1'b0;
        end else begin
            data_valid <= 1'b0;
            case (state)
                rx_idle: begin
                    bit_cnt <= '0;
                    if (!rx_sync) begin
                        state <= rx_start;
                    end
                end
                rx_start: begin
                    // Recheck the start bit at its middle
                    if (bit_cnt == baud_half) begin
                        bit_cnt <= '0;
                        bit_idx <= '0;
                        state   <= rx_sync ? rx_idle : rx_data;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                rx_data: begin
                    if (bit_cnt == baud_last) begin
                        bit_cnt <= '0;
                        if (bit_idx == 3'd7) begin
                            state <= rx_stop;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                rx_stop: begin
                    if (bit_cnt == baud_last) begin
                        // Framing error drops the byte
                        data_valid <= rx_sync;
                        state      <= rx_idle;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                default: state <= rx_idle;
            endcase
        end
    end

    // LSB first
    always_ff @(posedge sysclk) begin
        if (state == rx_data && bit_cnt == baud_last) begin
            data <= {rx_sync, data[7:1]};
        end
    end

endmodule

`default_nettype wire

/* tests/little_computer_tb.sv */
`default_nettype none

module little_computer_tb import lc_pkg::*; ();

    localparam int budget_margin = 100;
    localparam int cycles_per_instr = 8;

    logic        sysclk;
    logic        sysrst;
    logic        rx;
    logic        load_en;
    logic        out_ready;
    out_beat_t   out_beat;
    logic        halted;
    logic [31:0] lfsr;
    logic        random_ready;
    word_t       program_words[$];
    word_t       beats[$];
    string       test_name;
    int          cycle_count = 0;
    int          deadline = 1000;
    int          errors;
    int          errors_at_start;
    int          tests_run;
    int          tests_failed;

    little_computer little_computer_i (
        .sysclk    (sysclk),
        .sysrst    (sysrst),
        .rx        (rx),
        .load_en   (load_en),
        .out_ready (out_ready),
        .out_beat  (out_beat),
        .halted    (halted)
    );

    always #2 sysclk = ~sysclk;

    always @(posedge sysclk) begin
        cycle_count <= cycle_count + 1;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic word_t imm_instr(input opcode_e op, input logic [11:0] imm);
        return {op, imm};
    endfunction

    function automatic word_t mem_instr(input opcode_e op, input addr_t addr);
        return {op, 4'h0, addr};
    endfunction

    // Ready about one cycle in sixteen so a pending beat stalls the next store
    task automatic step_ready();
        logic all_ones;
        all_ones = 1'b1;
        for (int i = 0; i < 4; i++) begin
            lfsr = lfsr_next(lfsr);
            all_ones = all_ones & lfsr[0];
        end
        out_ready = all_ones;
    endtask

    // A beat counts when valid and ready meet at the next rising edge
    always @(negedge sysclk) begin
        if (random_ready) begin
            step_ready();
        end else begin
            out_ready = 1'b1;
        end
        if (sysrst && out_beat.valid && out_ready) begin
            beats.push_back(out_beat.data);
        end
    end

    initial begin
        while (cycle_count <= deadline) begin
            @(negedge sysclk);
        end
        $display("Watchdog: %s ran past its cycle budget at cycle %0d", test_name, cycle_count);
        $display("FAIL: see errors above");
        $finish;
    end

    task automatic set_budget(input int cycles);
        deadline = cycle_count + cycles + budget_margin;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge sysclk);
    endtask

    task automatic rand_word(output word_t w);
        w = '0;
        for (int i = 0; i < 16; i++) begin
            lfsr = lfsr_next(lfsr);
            w = {w[14:0], lfsr[0]};
        end
    endtask

    task automatic check_word(input word_t expected, input word_t actual);
        if (actual !== expected) begin
            errors++;
            $display("Fail %s: expected %h, actual %h", test_name, expected, actual);
        end
    endtask

    task automatic check_beat_count(input int expected, input int actual);
        if (actual != expected) begin
            errors++;
            $display("Fail %s: expected %0d beats, actual %0d", test_name, expected, actual);
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        errors_at_start = errors;
        tests_run++;
    endtask

    task automatic end_test();
        if (errors == errors_at_start) begin
            $display("Test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("Test %s: %0d errors", test_name, errors - errors_at_start);
        end
    endtask

    // 8N1 frame sent LSB first
    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            rx = frame[i];
            wait_cycles(clks_per_bit);
        end
    endtask

    task automatic send_word(input word_t w);
        send_byte(w[15:8]);
        send_byte(w[7:0]);
    endtask

    task automatic load_program(input int instr_count);
        set_budget(2 * program_words.size() * 10 * clks_per_bit
                   + cycles_per_instr * instr_count);
        beats.delete();
        load_en = 1'b1;
        wait_cycles(4);
        foreach (program_words[i]) begin
            send_word(program_words[i]);
        end
        // Let the last byte reach memory
        wait_cycles(2 * clks_per_bit);
        load_en = 1'b0;
        while (!halted) begin
            @(negedge sysclk);
        end
        // Final beat may still wait for out_ready
        while (out_beat.valid) begin
            @(negedge sysclk);
        end
        wait_cycles(2);
    endtask

    task automatic idle_after_reset();
        int halted_cycles;
        int valid_cycles;
        begin_test("idle_after_reset");
        set_budget(200);
        beats.delete();
        halted_cycles = 0;
        valid_cycles = 0;
        for (int i = 0; i < 200; i++) begin
            @(negedge sysclk);
            if (halted !== 1'b0) begin
                halted_cycles++;
            end
            if (out_beat.valid !== 1'b0) begin
                valid_cycles++;
            end
        end
        if (halted_cycles != 0) begin
            errors++;
            $display("Error in %s: halted was not low with no program loaded", test_name);
        end
        if (valid_cycles != 0) begin
            errors++;
            $display("Error in %s: out_beat.valid was not low with no program loaded",
                     test_name);
        end
        check_beat_count(0, beats.size());
        end_test();
    endtask

    task automatic single_beat();
        begin_test("single_beat");
        program_words = '{imm_instr(op_ldi, 12'h5a3), mem_instr(op_st, out_port_addr),
                          imm_instr(op_halt, 12'h000)};
        load_program(3);
        check_beat_count(1, beats.size());
        if (beats.size() > 0) begin
            check_word(16'h05a3, beats[0]);
        end
        end_test();
    endtask

    // Operands sit right after the four instructions
    task automatic run_arith(input opcode_e op, input word_t a, input word_t b,
                             input word_t expected);
        program_words = '{mem_instr(op_ld, 8'd4), mem_instr(op, 8'd5),
                          mem_instr(op_st, out_port_addr), imm_instr(op_halt, 12'h000), a, b};
        load_program(4);
        check_beat_count(1, beats.size());
        if (beats.size() > 0) begin
            check_word(expected, beats[0]);
        end
    endtask

    task automatic add_sub();
        word_t a;
        word_t b;
        begin_test("add_sub");
        rand_word(a);
        rand_word(b);
        run_arith(op_add, a, b, word_t'((int'(a) + int'(b)) % 65536));
        run_arith(op_sub, a, b, word_t'((int'(a) - int'(b) + 65536) % 65536));
        end_test();
    endtask

    // Counter lives at address 10 and the constant 1 at address 9
    task automatic countdown(input string name, input int n, input logic use_random);
        begin_test(name);
        program_words = '{imm_instr(op_ldi, 12'(n)), mem_instr(op_st, 8'd10),
                          mem_instr(op_ld, 8'd10), mem_instr(op_st, out_port_addr),
                          mem_instr(op_sub, 8'd9), mem_instr(op_st, 8'd10),
                          mem_instr(op_jz, 8'd8), mem_instr(op_jmp, 8'd2),
                          imm_instr(op_halt, 12'h000), 16'h0001};
        random_ready = use_random;
        load_program(6 * n + 2);
        random_ready = 1'b0;
        check_beat_count(n, beats.size());
        for (int i = 0; i < n && i < beats.size(); i++) begin
            check_word(word_t'(n - i), beats[i]);
        end
        end_test();
    endtask

    task automatic reload();
        begin_test("reload");
        program_words = '{imm_instr(op_ldi, 12'h111), mem_instr(op_st, out_port_addr),
                          imm_instr(op_ldi, 12'h222), mem_instr(op_st, out_port_addr),
                          imm_instr(op_halt, 12'h000)};
        load_program(5);
        check_beat_count(2, beats.size());
        // Shorter program must land from address 0 again
        program_words = '{imm_instr(op_ldi, 12'h333), mem_instr(op_st, out_port_addr),
                          imm_instr(op_halt, 12'h000)};
        load_program(3);
        check_beat_count(1, beats.size());
        if (beats.size() > 0) begin
            check_word(16'h0333, beats[0]);
        end
        end_test();
    endtask

    initial begin
        sysclk = 1'b0;
        sysrst = 1'b0;
        rx = 1'b1;
        load_en = 1'b0;
        out_ready = 1'b1;
        random_ready = 1'b0;
        lfsr = 32'h4c7b1fea;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        test_name = "reset";
        wait_cycles(4);
        sysrst = 1'b1;
        wait_cycles(2);
        idle_after_reset();
        single_beat();
        add_sub();
        countdown("countdown", 5, 1'b0);
        countdown("countdown_backpressure", 5, 1'b1);
        reload();
        $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire
